// File: rtl/mopshub_pkg.sv
// ####################
// shared sizes, types and state encoding for the receive side
// of the can hub node. every rtl block imports this package
// ####################

package mopshub_pkg;

   localparam int NUM_BUS     = 32;
   localparam int BUS_SEL_W   = 5;
   localparam int DATA_W      = 16;
   localparam int ACK_TIMEOUT = 200;   // cycles before the host is given up on

   // index of one can bus
   typedef logic [BUS_SEL_W-1:0] bus_sel_t;

   // word received from one bus controller
   typedef logic [DATA_W-1:0] bus_data_t;

   // one bit per bus
   typedef logic [NUM_BUS-1:0] bus_mask_t;

   // receive state machine
   typedef enum logic [1:0] {
      ST_IDLE     = 2'd0,   // nothing pending, pointer rests
      ST_SCAN     = 2'd1,   // walking the pointer
      ST_SERVE    = 2'd2,   // word captured, irq next
      ST_WAIT_ACK = 2'd3    // irq high, waiting on host
   } sm_state_t;

endpackage

// File: rtl/rec_pending_flags.sv
// ####################
// sticky receive-pending flags, one per can bus
// can_rec bits set them, the state machine clears the
// flag under the scan pointer when that bus is served
// ####################

`timescale 1ns/100ps

module rec_pending_flags (
   input  logic                   clock,
   input  logic                   reset,
   input  mopshub_pkg::bus_mask_t can_rec,
   input  logic                   clear_en,
   input  mopshub_pkg::bus_sel_t  ptr,
   output mopshub_pkg::bus_mask_t pending
);
   import mopshub_pkg::*;

   bus_mask_t clr_mask;   // one-hot of the served bus

   always_comb begin
      clr_mask = '0;
      if (clear_en) begin
         clr_mask[ptr] = 1'b1;
      end
   end

   // set wins over clear on the same bit
   always_ff @(posedge clock) begin
      if (reset) begin
         pending <= '0;
      end else begin
         pending <= (pending & ~clr_mask) | can_rec;
      end
   end

endmodule

// File: rtl/bus_scan_counter.sv
// ####################
// round-robin bus pointer for the receive scan
// steps by one on advance and wraps after the last bus
// ####################

`timescale 1ns/100ps

module bus_scan_counter (
   input  logic                  clock,
   input  logic                  reset,
   input  logic                  advance,
   output mopshub_pkg::bus_sel_t ptr
);
   import mopshub_pkg::*;

   localparam bus_sel_t LAST_BUS = bus_sel_t'(NUM_BUS - 1);

   bus_sel_t ptr_next;

   always_comb begin
      ptr_next = ptr;   // hold by default
      if (advance) begin
         if (ptr == LAST_BUS) begin
            ptr_next = '0;
         end else begin
            ptr_next = ptr + 1'b1;
         end
      end
   end

   always_ff @(posedge clock) begin
      if (reset) begin
         ptr <= '0;
      end else begin
         ptr <= ptr_next;
      end
   end

endmodule

// File: rtl/ack_timer.sv
// ####################
// acknowledge watchdog, counts cycles while the host owes
// an answer and flags expiry after ACK_TIMEOUT cycles
// ####################

`timescale 1ns/100ps

module ack_timer (
   input  logic clock,
   input  logic reset,
   input  logic timer_run,
   output logic expired
);
   import mopshub_pkg::*;

   logic [$clog2(ACK_TIMEOUT+1)-1:0] count;

   assign expired = (count == ACK_TIMEOUT);

   always_ff @(posedge clock) begin
      if (reset) begin
         count <= '0;
      end else if (!timer_run) begin
         count <= '0;   // restart for every wait
      end else if (!expired) begin
         count <= count + 1'b1;
      end
   end

endmodule

// File: rtl/readdata_latch.sv
// ####################
// lane select and holding registers for the host side
// word and bus number stay frozen until the next capture
// ####################

`timescale 1ns/100ps

module readdata_latch (
   input  logic                   clock,
   input  logic                   reset,
   input  logic                   capture,
   input  mopshub_pkg::bus_sel_t  ptr,
   input  mopshub_pkg::bus_data_t readdata_in [mopshub_pkg::NUM_BUS],
   output mopshub_pkg::bus_data_t readdata,
   output mopshub_pkg::bus_sel_t  bus_rec_select
);
   import mopshub_pkg::*;

   bus_data_t lane_word;

   assign lane_word = readdata_in[ptr];   // 32 to 1 mux

   always_ff @(posedge clock) begin
      if (reset) begin
         readdata       <= '0;
         bus_rec_select <= '0;
      end else if (capture) begin
         readdata       <= lane_word;
         bus_rec_select <= ptr;
      end
   end

endmodule

// File: rtl/node_readdata_sm.sv
// ####################
// receive state machine, walks the scan pointer over the
// pending flags, serves one bus at a time to the host and
// raises the irq, end-of-batch and timeout pulses
// ####################

`timescale 1ns/100ps

module node_readdata_sm (
   input  logic                   clock,
   input  logic                   reset,
   input  mopshub_pkg::bus_mask_t pending,
   input  mopshub_pkg::bus_sel_t  ptr,
   input  logic                   ireqsucrec,
   input  logic                   expired,
   output logic                   clear_en,
   output logic                   advance,
   output logic                   capture,
   output logic                   timer_run,
   output logic                   irq_can_rec,
   output logic                   choose_bus_end,
   output logic                   timeout_err
);
   import mopshub_pkg::*;

   sm_state_t state;
   sm_state_t next_state;
   logic      hit;    // pointed bus has a request
   logic      done;   // host answered or gave up
   logic      any_pending;

   assign hit         = pending[ptr];
   assign done        = ireqsucrec | expired;
   assign any_pending = |pending;

   always_comb begin
      next_state = state;
      clear_en   = 1'b0;
      advance    = 1'b0;
      capture    = 1'b0;
      timer_run  = 1'b0;
      case (state)
         ST_IDLE: begin
            if (any_pending) begin
               next_state = ST_SCAN;
            end
         end
         ST_SCAN: begin
            if (hit) begin
               capture    = 1'b1;   // lane word and ptr into the latch
               clear_en   = 1'b1;
               next_state = ST_SERVE;
            end else if (any_pending) begin
               advance = 1'b1;
            end else begin
               next_state = ST_IDLE;
            end
         end
         ST_SERVE: begin
            next_state = ST_WAIT_ACK;
         end
         ST_WAIT_ACK: begin
            if (done) begin
               advance = 1'b1;   // move past the served bus
               if (any_pending) begin
                  next_state = ST_SCAN;
               end else begin
                  next_state = ST_IDLE;
               end
            end else begin
               timer_run = 1'b1;
            end
         end
         default: begin
            next_state = ST_IDLE;
         end
      endcase
   end

   // registered outputs, irq follows the wait state
   always_ff @(posedge clock) begin
      if (reset) begin
         state          <= ST_IDLE;
         irq_can_rec    <= 1'b0;
         choose_bus_end <= 1'b0;
         timeout_err    <= 1'b0;
      end else begin
         state          <= next_state;
         irq_can_rec    <= (next_state == ST_WAIT_ACK);
         choose_bus_end <= (state == ST_WAIT_ACK) && (next_state == ST_IDLE);
         timeout_err    <= (state == ST_WAIT_ACK) && expired && !ireqsucrec;
      end
   end

endmodule

// File: rtl/node_readdata_top.sv
// ####################
// receive side of the can hub node
// collects words from 32 can buses and hands them one at a
// time to the host over irq_can_rec / ireqsucrec
// ####################

`timescale 1ns/100ps

module node_readdata_top (
   input  logic                   clock,
   input  logic                   reset,
   input  mopshub_pkg::bus_mask_t can_rec,
   input  mopshub_pkg::bus_data_t readdata_in [mopshub_pkg::NUM_BUS],
   input  logic                   ireqsucrec,
   output mopshub_pkg::bus_sel_t  bus_rec_select,
   output mopshub_pkg::bus_data_t readdata,
   output logic                   irq_can_rec,
   output logic                   choose_bus_end,
   output logic                   timeout_err
);
   import mopshub_pkg::*;

   bus_mask_t pending;
   bus_sel_t  ptr;
   logic      clear_en;
   logic      advance;
   logic      capture;
   logic      timer_run;
   logic      expired;

   rec_pending_flags flags_i (
      .clock    (clock),
      .reset    (reset),
      .can_rec  (can_rec),
      .clear_en (clear_en),
      .ptr      (ptr),
      .pending  (pending)
   );

   bus_scan_counter scan_i (
      .clock   (clock),
      .reset   (reset),
      .advance (advance),
      .ptr     (ptr)
   );

   ack_timer timer_i (
      .clock     (clock),
      .reset     (reset),
      .timer_run (timer_run),
      .expired   (expired)
   );

   readdata_latch latch_i (
      .clock          (clock),
      .reset          (reset),
      .capture        (capture),
      .ptr            (ptr),
      .readdata_in    (readdata_in),
      .readdata       (readdata),
      .bus_rec_select (bus_rec_select)
   );

   node_readdata_sm sm_i (
      .clock          (clock),
      .reset          (reset),
      .pending        (pending),
      .ptr            (ptr),
      .ireqsucrec     (ireqsucrec),
      .expired        (expired),
      .clear_en       (clear_en),
      .advance        (advance),
      .capture        (capture),
      .timer_run      (timer_run),
      .irq_can_rec    (irq_can_rec),
      .choose_bus_end (choose_bus_end),
      .timeout_err    (timeout_err)
   );

endmodule

// File: tb/tb_node_readdata.sv
// ####################
// self-checking testbench for the can hub receive side
// applies a table of request batches, serves every irq like a
// host would and checks words, bus numbers and pulses against
// a round-robin reference model
// ####################

`timescale 1ns/100ps

module tb_node_readdata;
   import mopshub_pkg::*;

   localparam int          WAIT_LIMIT = ACK_TIMEOUT + 100;
   localparam int unsigned SEED       = 32'h780d_e0cd;
   localparam int          NUM_ROWS   = 7;

   // one batch of requests
   typedef struct packed {
      bus_mask_t mask;      // buses requesting at batch start
      int        delay;     // host delay before each ack
      logic      no_ack;    // first service never acknowledged
      bus_mask_t extra;     // requests issued while the first irq waits
      int        exp_srv;   // expected number of services
   } row_t;

   logic      clock;
   logic      reset;
   bus_mask_t can_rec;
   bus_data_t lanes [NUM_BUS];
   logic      ireqsucrec;
   bus_sel_t  bus_rec_select;
   bus_data_t readdata;
   logic      irq_can_rec;
   logic      choose_bus_end;
   logic      timeout_err;

   row_t        rows [NUM_ROWS];
   bus_data_t   req_word [NUM_BUS];   // lane word at the last request
   bus_mask_t   model_pending;
   bus_sel_t    model_ptr;
   bus_sel_t    model_sel;    // last bus handed to the host
   bus_data_t   model_word;   // last word handed to the host
   int          value_errors;
   int          other_errors;
   int          end_seen;
   int          tmo_seen;
   int          irq_rises;
   logic        irq_prev;

   node_readdata_top dut_i (
      .clock          (clock),
      .reset          (reset),
      .can_rec        (can_rec),
      .readdata_in    (lanes),
      .ireqsucrec     (ireqsucrec),
      .bus_rec_select (bus_rec_select),
      .readdata       (readdata),
      .irq_can_rec    (irq_can_rec),
      .choose_bus_end (choose_bus_end),
      .timeout_err    (timeout_err)
   );

   always #10 clock = ~clock;

   // pulse counters, sampled mid-cycle
   always @(negedge clock) begin
      if (choose_bus_end === 1'b1) end_seen++;
      if (timeout_err === 1'b1) tmo_seen++;
      if (irq_can_rec === 1'b1 && irq_prev !== 1'b1) irq_rises++;
      irq_prev = irq_can_rec;
   end

   task check_sel(input string name, input bus_sel_t got, input bus_sel_t exp);
      if (got !== exp) begin
         value_errors++;
         $display("FAILED time %0t: %s = %0d, expected %0d", $time, name, got, exp);
      end
   endtask

   task check_data(input string name, input bus_data_t got, input bus_data_t exp);
      if (got !== exp) begin
         value_errors++;
         $display("FAILED time %0t: %s = %04h, expected %04h", $time, name, got, exp);
      end
   endtask

   task check_bit(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         value_errors++;
         $display("FAILED time %0t: %s = %b, expected %b", $time, name, got, exp);
      end
   endtask

   task check_count(input string name, input int got, input int exp);
      if (got != exp) begin
         value_errors++;
         $display("FAILED time %0t: %s = %0d, expected %0d", $time, name, got, exp);
      end
   endtask

   // first pending bus at or above the pointer, with wrap
   function automatic bus_sel_t predict_bus(input bus_mask_t mask, input bus_sel_t from);
      int b;
      for (int i = 0; i < NUM_BUS; i++) begin
         b = (int'(from) + i) % NUM_BUS;
         if (mask[b]) return bus_sel_t'(b);
      end
      return from;
   endfunction

   task load_rows();
      //          mask          delay no_ack extra         exp_srv
      rows[0] = '{32'h0000_0000, 0,   1'b0, 32'h0000_0000, 0};    // stray ack only
      rows[1] = '{32'h0000_0200, 2,   1'b0, 32'h0000_0000, 1};    // single bus 9
      rows[2] = '{32'h8000_1060, 0,   1'b0, 32'h0000_0000, 4};    // 12, 31, wrap, 5, 6
      rows[3] = '{32'h0010_0008, 4,   1'b0, 32'h0200_0108, 4};    // back-pressure, 3 merges
      rows[4] = '{32'h4000_4000, 1,   1'b1, 32'h0000_0000, 2};    // 14 times out
      rows[5] = '{32'hffff_ffff, 0,   1'b0, 32'h0000_0000, 32};
      rows[6] = '{32'h0000_0000, 0,   1'b0, 32'h0000_0000, 0};
   endtask

   // fresh words on the requested lanes plus a one-cycle can_rec pulse
   task issue_requests(input bus_mask_t mask);
      bus_data_t w;
      for (int b = 0; b < NUM_BUS; b++) begin
         if (mask[b]) begin
            w = bus_data_t'($urandom);
            lanes[b] <= w;
            req_word[b] = w;
         end
      end
      model_pending = model_pending | mask;
      can_rec <= mask;
      @(posedge clock);
      can_rec <= '0;
   endtask

   task wait_irq(output logic ok);
      int n;
      n = 0;
      @(posedge clock);
      while (irq_can_rec !== 1'b1 && n < WAIT_LIMIT) begin
         @(posedge clock);
         n++;
      end
      ok = (irq_can_rec === 1'b1);
      if (!ok) begin
         other_errors++;
         $display("time %0t: irq_can_rec did not rise within %0d cycles", $time, WAIT_LIMIT);
      end
   endtask

   task hold_then_ack(input int d, input bus_sel_t exp_sel, input bus_data_t exp_word);
      repeat (d) begin
         @(posedge clock);
         check_bit("irq_can_rec", irq_can_rec, 1'b1);
         check_sel("bus_rec_select", bus_rec_select, exp_sel);
         check_data("readdata", readdata, exp_word);
      end
      ireqsucrec <= 1'b1;
      @(posedge clock);
      ireqsucrec <= 1'b0;
      @(posedge clock);
      check_bit("irq_can_rec", irq_can_rec, 1'b0);   // falls on the ack edge
      check_bit("timeout_err", timeout_err, 1'b0);
      @(posedge clock);
      check_bit("irq_can_rec", irq_can_rec, 1'b0);   // low for one more cycle
   endtask

   task let_ack_expire(input bus_data_t exp_word);
      int n;
      n = 0;
      while (irq_can_rec === 1'b1 && n < WAIT_LIMIT) begin
         @(posedge clock);
         n++;
         if (irq_can_rec === 1'b1) check_data("readdata", readdata, exp_word);
      end
      if (irq_can_rec === 1'b1) begin
         other_errors++;
         $display("time %0t: irq_can_rec stayed high without an acknowledge", $time);
      end else begin
         if (n < ACK_TIMEOUT) begin
            other_errors++;
            $display("time %0t: irq_can_rec dropped after only %0d cycles", $time, n);
         end
         check_bit("timeout_err", timeout_err, 1'b1);
         @(posedge clock);
         check_bit("timeout_err", timeout_err, 1'b0);   // one cycle only
         check_bit("irq_can_rec", irq_can_rec, 1'b0);
      end
   endtask

   task serve_bus(input int d, input logic withhold, input bus_mask_t extra);
      logic      ok;
      bus_sel_t  exp_sel;
      bus_data_t exp_word;
      exp_sel  = predict_bus(model_pending, model_ptr);
      exp_word = req_word[exp_sel];
      model_pending[exp_sel] = 1'b0;
      model_ptr  = bus_sel_t'((int'(exp_sel) + 1) % NUM_BUS);
      model_sel  = exp_sel;
      model_word = exp_word;
      wait_irq(ok);
      if (ok) begin
         check_sel("bus_rec_select", bus_rec_select, exp_sel);
         check_data("readdata", readdata, exp_word);
         if (extra != '0) begin
            lanes[exp_sel] <= ~exp_word;   // controller overwrites the served lane
            issue_requests(extra);
         end
         if (withhold) begin
            let_ack_expire(exp_word);
         end else begin
            hold_then_ack(d, exp_sel, exp_word);
         end
      end
   endtask

   task wait_batch_end(input int end_base);
      int n;
      n = 0;
      while (end_seen == end_base && n < WAIT_LIMIT) begin
         @(posedge clock);
         n++;
      end
      if (end_seen == end_base) begin
         other_errors++;
         $display("time %0t: no choose_bus_end pulse after the batch", $time);
      end
   endtask

   task run_row(input int r);
      int        srv;
      int        end_base;
      int        tmo_base;
      int        irq_base;
      bus_mask_t extra;
      logic      withhold;
      srv      = 0;
      end_base = end_seen;
      tmo_base = tmo_seen;
      irq_base = irq_rises;
      issue_requests(rows[r].mask);
      while (model_pending != '0) begin
         withhold = rows[r].no_ack && (srv == 0);
         extra    = (srv == 0) ? rows[r].extra : '0;
         serve_bus(rows[r].delay + int'($urandom % 3), withhold, extra);
         srv++;
      end
      wait_batch_end(end_base);
      repeat (3) @(posedge clock);
      check_bit("irq_can_rec", irq_can_rec, 1'b0);
      check_bit("choose_bus_end", choose_bus_end, 1'b0);
      check_count("services", irq_rises - irq_base, rows[r].exp_srv);
      check_count("choose_bus_end pulses", end_seen - end_base, 1);
      check_count("timeout_err pulses", tmo_seen - tmo_base, rows[r].no_ack ? 1 : 0);
   endtask

   // ack with no irq pending must change nothing
   task stray_ack_probe();
      int end_base;
      int tmo_base;
      end_base = end_seen;
      tmo_base = tmo_seen;
      ireqsucrec <= 1'b1;
      repeat (2) @(posedge clock);
      ireqsucrec <= 1'b0;
      repeat (6) begin
         @(posedge clock);
         check_bit("irq_can_rec", irq_can_rec, 1'b0);
         check_data("readdata", readdata, model_word);
         check_sel("bus_rec_select", bus_rec_select, model_sel);
      end
      check_count("choose_bus_end pulses", end_seen - end_base, 0);
      check_count("timeout_err pulses", tmo_seen - tmo_base, 0);
   endtask

   initial begin
      void'($urandom(SEED));
      value_errors  = 0;
      other_errors  = 0;
      end_seen      = 0;
      tmo_seen      = 0;
      irq_rises     = 0;
      irq_prev      = 1'b0;
      model_pending = '0;
      model_ptr     = '0;
      model_sel     = '0;
      model_word    = '0;
      clock         = 1'b0;
      reset      <= 1'b1;
      can_rec    <= '0;
      ireqsucrec <= 1'b0;
      for (int i = 0; i < NUM_BUS; i++) begin
         req_word[i] = bus_data_t'($urandom);
         lanes[i] <= req_word[i];
      end
      load_rows();
      repeat (5) @(posedge clock);
      reset <= 1'b0;
      repeat (3) begin
         @(posedge clock);
         check_bit("irq_can_rec", irq_can_rec, 1'b0);
         check_bit("choose_bus_end", choose_bus_end, 1'b0);
         check_bit("timeout_err", timeout_err, 1'b0);
         check_data("readdata", readdata, '0);
         check_sel("bus_rec_select", bus_rec_select, '0);
      end
      for (int r = 0; r < NUM_ROWS; r++) begin
         if (rows[r].mask == '0) begin
            stray_ack_probe();
         end else begin
            run_row(r);
         end
      end
      $display("value errors: %0d, other failures: %0d", value_errors, other_errors);
      if (value_errors == 0 && other_errors == 0) begin
         $display("TEST PASS");
      end else begin
         $display("TEST FAIL");
      end
      $finish;
   end

endmodule

// File: tb.f
rtl/mopshub_pkg.sv
rtl/rec_pending_flags.sv
rtl/bus_scan_counter.sv
rtl/ack_timer.sv
rtl/readdata_latch.sv
rtl/node_readdata_sm.sv
rtl/node_readdata_top.sv
tb/tb_node_readdata.sv

// File: Bender.yml
package:
  name: node_readdata

sources:
  - files:
      - rtl/mopshub_pkg.sv
      - rtl/rec_pending_flags.sv
      - rtl/bus_scan_counter.sv
      - rtl/ack_timer.sv
      - rtl/readdata_latch.sv
      - rtl/node_readdata_sm.sv
      - rtl/node_readdata_top.sv
  - target: simulation
    files:
      - tb/tb_node_readdata.sv
